/* logic/adc_pkg.sv */
`default_nettype none

package adc_pkg;

    // sample and frame sizes
    localparam int W_DATA  = 18;
    localparam int W_CHAN  = 3;
    localparam int N_CHAN  = 8;
    localparam int W_FRAME = 24;
    localparam int W_PAD   = W_FRAME - W_CHAN - W_DATA;

    // frame timing in system clocks, two clocks per serial bit
    localparam int FRAME_CYCLES = 64;
    localparam int SHIFT_CYCLES = 48;
    localparam int W_FCNT       = $clog2(FRAME_CYCLES);

    // oversampling
    localparam int N_OVS    = 4;
    localparam int LOG2_OVS = 2;
    localparam int W_ACC    = W_DATA + LOG2_OVS;

    // serializer state codes
    localparam int W_STATE = 3;
    localparam logic [W_STATE-1:0] ST_WAIT_DVH = 3'd0;
    localparam logic [W_STATE-1:0] ST_HOLD     = 3'd1;
    localparam logic [W_STATE-1:0] ST_SEND_A   = 3'd2;
    localparam logic [W_STATE-1:0] ST_SEND_B   = 3'd3;
    localparam logic [W_STATE-1:0] ST_WAIT_DVL = 3'd4;

    // serial frame, seen as shifted bits or as decoded fields
    typedef union packed {
        logic [W_FRAME-1:0] raw;
        struct packed {
            logic [W_CHAN-1:0] chan;
            logic [W_PAD-1:0]  pad;
            logic [W_DATA-1:0] data;
        } fields;
    } adc_frame_t;

    // decoded sample as passed between blocks
    typedef struct packed {
        logic [W_CHAN-1:0] chan;
        logic [W_DATA-1:0] data;
    } adc_sample_t;

endpackage

`default_nettype wire

/* logic/adc_serial_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_serial_reader import adc_pkg::*; (
    input  wire logic        sys_clk_in,
    input  wire logic        reset_in,
    // converter serial port
    input  wire logic        sdo,
    output logic             cs_n,
    output logic             sclk,
    // decoded sample
    output logic             dv,
    output adc_sample_t      sample
);

    //////////////////////////////////////////////////
    // frame counter
    //////////////////////////////////////////////////

    logic [W_FCNT-1:0] frame_cnt;
    logic [W_FCNT-1:0] cnt_next;
    logic              in_window_next;
    logic              shift_en;
    logic              frame_end;
    logic              frame_start;
    adc_frame_t        frame;

    // wraps at the last count of the frame
    assign cnt_next = (frame_cnt == W_FCNT'(FRAME_CYCLES - 1)) ? '0 : frame_cnt + 1'b1;

    // chip select window for the coming cycle
    assign in_window_next = cnt_next < W_FCNT'(SHIFT_CYCLES);

    // sclk goes high on odd counts, bit taken on that edge
    assign shift_en = in_window_next & cnt_next[0];

    // last cycle with cs_n low, frame fully shifted in
    assign frame_end = frame_cnt == W_FCNT'(SHIFT_CYCLES - 1);

    // cs_n about to fall
    assign frame_start = cnt_next == '0;

    // held at the last count so count 0 is the first cycle out of reset
    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            frame_cnt <= W_FCNT'(FRAME_CYCLES - 1);
        end else begin
            frame_cnt <= cnt_next;
        end
    end

    //////////////////////////////////////////////////
    // serial port outputs
    //////////////////////////////////////////////////

    // both registered from the next count, no glitches on the pins
    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            cs_n <= 1'b1;
            sclk <= 1'b0;
        end else begin
            cs_n <= ~in_window_next;
            sclk <= shift_en;
        end
    end

    //////////////////////////////////////////////////
    // shift and decode
    //////////////////////////////////////////////////

    // msb first into the raw view
    always_ff @(posedge sys_clk_in) begin
        if (shift_en) begin
            frame.raw <= {frame.raw[W_FRAME-2:0], sdo};
        end
    end

    // pad bits dropped here
    always_ff @(posedge sys_clk_in) begin
        if (frame_end) begin
            sample.chan <= frame.fields.chan;
            sample.data <= frame.fields.data;
        end
    end

    // valid from frame end until next cs_n fall
    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            dv <= 1'b0;
        end else if (frame_end) begin
            dv <= 1'b1;
        end else if (frame_start) begin
            dv <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/sample_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_serializer import adc_pkg::*; (
    input  wire logic        sys_clk_in,
    input  wire logic        reset_in,
    // from the two readers
    input  wire logic        dv_a,
    input  wire logic        dv_b,
    input  wire adc_sample_t sample_a,
    input  wire adc_sample_t sample_b,
    // to the filter
    output logic             word_valid,
    output adc_sample_t      word
);

    //////////////////////////////////////////////////
    // internal state
    //////////////////////////////////////////////////

    logic [W_STATE-1:0] cur_state;
    logic [W_STATE-1:0] next_state;
    adc_sample_t        word_a;
    adc_sample_t        word_b;
    logic               both_high;
    logic               both_low;

    assign both_high = dv_a & dv_b;
    assign both_low  = ~dv_a & ~dv_b;

    //////////////////////////////////////////////////
    // sample latches
    //////////////////////////////////////////////////

    // taken as the fsm leaves the wait state
    always_ff @(posedge sys_clk_in) begin
        if (cur_state == ST_WAIT_DVH && both_high) begin
            word_a <= sample_a;
            word_b <= sample_b;
        end
    end

    //////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            cur_state <= ST_WAIT_DVH;
        end else begin
            cur_state <= next_state;
        end
    end

    always_comb begin
        next_state = cur_state;
        case (cur_state)
            // both readers must have a fresh sample
            ST_WAIT_DVH: begin
                if (both_high) begin
                    next_state = ST_HOLD;
                end
            end
            // one cycle of hold on the latched words
            ST_HOLD:   next_state = ST_SEND_A;
            ST_SEND_A: next_state = ST_SEND_B;
            ST_SEND_B: next_state = ST_WAIT_DVL;
            // rearm only once both frames have restarted
            ST_WAIT_DVL: begin
                if (both_low) begin
                    next_state = ST_WAIT_DVH;
                end
            end
            default:   next_state = ST_WAIT_DVH;
        endcase
    end

    //////////////////////////////////////////////////
    // output decode
    //////////////////////////////////////////////////

    // a first then b, zero elsewhere
    always_comb begin
        case (cur_state)
            ST_SEND_A: begin
                word_valid = 1'b1;
                word       = word_a;
            end
            ST_SEND_B: begin
                word_valid = 1'b1;
                word       = word_b;
            end
            default: begin
                word_valid = 1'b0;
                word       = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/oversample_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module oversample_filter import adc_pkg::*; (
    input  wire logic              sys_clk_in,
    input  wire logic              reset_in,
    // serialized words
    input  wire logic              word_valid,
    input  wire adc_sample_t       word,
    // averaged result
    output logic                   avg_valid,
    output logic [W_CHAN-1:0]      avg_chan,
    output logic [W_DATA-1:0]      avg_data
);

    //////////////////////////////////////////////////
    // per-channel accumulators
    //////////////////////////////////////////////////

    logic [W_ACC-1:0]    acc   [N_CHAN];
    logic [LOG2_OVS-1:0] count [N_CHAN];
    logic [W_ACC-1:0]    acc_sum;
    logic                last_sample;

    // running sum including the incoming word
    assign acc_sum = acc[word.chan] + W_ACC'(word.data);

    // this word completes the set for its channel
    assign last_sample = count[word.chan] == LOG2_OVS'(N_OVS - 1);

    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            for (int i = 0; i < N_CHAN; i++) begin
                acc[i]   <= '0;
                count[i] <= '0;
            end
        end else if (word_valid) begin
            // channel starts over after its result
            if (last_sample) begin
                acc[word.chan]   <= '0;
                count[word.chan] <= '0;
            end else begin
                acc[word.chan]   <= acc_sum;
                count[word.chan] <= count[word.chan] + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk_in) begin
        if (reset_in) begin
            avg_valid <= 1'b0;
        end else begin
            avg_valid <= word_valid & last_sample;
        end
    end

    // divide by shift, low bits truncated
    always_ff @(posedge sys_clk_in) begin
        if (word_valid && last_sample) begin
            avg_chan <= word.chan;
            avg_data <= acc_sum[W_ACC-1:LOG2_OVS];
        end
    end

endmodule

`default_nettype wire

/* logic/adc_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_subsystem import adc_pkg::*; (
    input  wire logic         sys_clk_in,
    input  wire logic         reset_in,
    // converter a
    output logic              adc_a_cs_n,
    output logic              adc_a_sclk,
    input  wire logic         adc_a_sdo,
    // converter b
    output logic              adc_b_cs_n,
    output logic              adc_b_sclk,
    input  wire logic         adc_b_sdo,
    // averaged results
    output logic              avg_valid,
    output logic [W_CHAN-1:0] avg_chan,
    output logic [W_DATA-1:0] avg_data
);

    //////////////////////////////////////////////////
    // interconnect
    //////////////////////////////////////////////////

    adc_sample_t sample_a;
    adc_sample_t sample_b;
    logic        dv_a;
    logic        dv_b;
    adc_sample_t word;
    logic        word_valid;

    // readers share reset so their frames stay aligned
    adc_serial_reader reader_a (
        .sys_clk_in (sys_clk_in),
        .reset_in   (reset_in),
        .sdo        (adc_a_sdo),
        .cs_n       (adc_a_cs_n),
        .sclk       (adc_a_sclk),
        .dv         (dv_a),
        .sample     (sample_a)
    );

    adc_serial_reader reader_b (
        .sys_clk_in (sys_clk_in),
        .reset_in   (reset_in),
        .sdo        (adc_b_sdo),
        .cs_n       (adc_b_cs_n),
        .sclk       (adc_b_sclk),
        .dv         (dv_b),
        .sample     (sample_b)
    );

    // two samples in, one word at a time out
    sample_serializer sample_serializer (
        .sys_clk_in (sys_clk_in),
        .reset_in   (reset_in),
        .dv_a       (dv_a),
        .dv_b       (dv_b),
        .sample_a   (sample_a),
        .sample_b   (sample_b),
        .word_valid (word_valid),
        .word       (word)
    );

    oversample_filter oversample_filter (
        .sys_clk_in (sys_clk_in),
        .reset_in   (reset_in),
        .word_valid (word_valid),
        .word       (word),
        .avg_valid  (avg_valid),
        .avg_chan   (avg_chan),
        .avg_data   (avg_data)
    );

endmodule

`default_nettype wire

/* bench/sample_serializer_props.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_serializer_props (
    input wire logic sys_clk_in,
    input wire logic reset_in,
    input wire logic dv_a,
    input wire logic dv_b,
    input wire logic word_valid
);

    //////////////////////////////////////////////////
    // serializer output rules
    //////////////////////////////////////////////////

    // fsm sits in the wait state right after a reset edge
    valid_low_in_reset: assert property (
        @(posedge sys_clk_in) reset_in |=> !word_valid
    ) else $error("word_valid high during reset");

    // a and b words only, never a third
    no_three_words: assert property (
        @(posedge sys_clk_in) disable iff (reset_in)
        word_valid ##1 word_valid |=> !word_valid
    ) else $error("word_valid high for three cycles in a row");

    // wait state, hold, then word a
    // both dv first seen high exactly two cycles before
    rise_after_both_dv: assert property (
        @(posedge sys_clk_in) disable iff (reset_in)
        $rose(word_valid) |-> $past(dv_a && dv_b, 2) && !$past(dv_a && dv_b, 3)
    ) else $error("word_valid did not rise exactly two cycles after both dv went high");

endmodule

bind sample_serializer sample_serializer_props props (
    .sys_clk_in (sys_clk_in),
    .reset_in   (reset_in),
    .dv_a       (dv_a),
    .dv_b       (dv_b),
    .word_valid (word_valid)
);

`default_nettype wire

/* bench/adc_subsystem_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_subsystem_tb import adc_pkg::*; ();

    //////////////////////////////////////////////////
    // dut signals
    //////////////////////////////////////////////////

    logic              sys_clk_in;
    logic              reset_in;
    logic [1:0]        sdo_bits;
    logic              adc_a_cs_n;
    logic              adc_a_sclk;
    logic              adc_b_cs_n;
    logic              adc_b_sclk;
    logic              avg_valid;
    logic [W_CHAN-1:0] avg_chan;
    logic [W_DATA-1:0] avg_data;
    logic [1:0]        cs_bus;
    logic [1:0]        sclk_bus;

    // index 0 is converter a, index 1 is converter b
    assign cs_bus   = {adc_b_cs_n, adc_a_cs_n};
    assign sclk_bus = {adc_b_sclk, adc_a_sclk};

    adc_subsystem uut (
        .sys_clk_in (sys_clk_in),
        .reset_in   (reset_in),
        .adc_a_cs_n (adc_a_cs_n),
        .adc_a_sclk (adc_a_sclk),
        .adc_a_sdo  (sdo_bits[0]),
        .adc_b_cs_n (adc_b_cs_n),
        .adc_b_sclk (adc_b_sclk),
        .adc_b_sdo  (sdo_bits[1]),
        .avg_valid  (avg_valid),
        .avg_chan   (avg_chan),
        .avg_data   (avg_data)
    );

    always #50 sys_clk_in = ~sys_clk_in;

    //////////////////////////////////////////////////
    // bookkeeping
    //////////////////////////////////////////////////

    int          mismatch_errs    = 0;
    int          protocol_errs    = 0;
    int          timeout_errs     = 0;
    int          frames_done      = 0;
    int          same_chan_frames = 0;
    int          exp_total        = 0;
    int          avg_seen         = 0;
    logic [31:0] lfsr_state       = 32'hc124_0b73;
    adc_sample_t exp_q [$];
    int unsigned model_sum [N_CHAN];
    int          model_cnt [N_CHAN];

    // converter models
    adc_frame_t  tx_frame [2];
    int          tx_bit   [2];
    logic [1:0]  cs_prev;

    // frame monitor
    logic [1:0]  mon_cs_prev;
    logic [1:0]  sclk_prev;
    logic [1:0]  seen_fall;
    int          low_cnt    [2];
    int          rise_cnt   [2];
    int          period_cnt [2];

    //////////////////////////////////////////////////
    // random source and reference model
    //////////////////////////////////////////////////

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_take_bit()};
        end
        return v;
    endfunction

    // channel first, then data, pad stays zero
    function automatic adc_frame_t pick_frame();
        adc_frame_t f;
        f.raw = '0;
        f.fields.chan = W_CHAN'(random_bits(W_CHAN));
        f.fields.data = W_DATA'(random_bits(W_DATA));
        return f;
    endfunction

    // one sample into its channel, result queued on the fourth
    function automatic void ref_add(input logic [W_CHAN-1:0] chan, input logic [W_DATA-1:0] data);
        adc_sample_t e;
        model_sum[chan] += data;
        model_cnt[chan]++;
        if (model_cnt[chan] == N_OVS) begin
            e.chan = chan;
            // integer divide truncates like the hardware shift
            e.data = W_DATA'(model_sum[chan] / N_OVS);
            exp_q.push_back(e);
            exp_total++;
            model_sum[chan] = 0;
            model_cnt[chan] = 0;
        end
    endfunction

    // a before b within a frame
    function automatic void ref_frame(input adc_frame_t fa, input adc_frame_t fb);
        if (fa.fields.chan == fb.fields.chan) begin
            same_chan_frames++;
        end
        ref_add(fa.fields.chan, fa.fields.data);
        ref_add(fb.fields.chan, fb.fields.data);
    endfunction

    //////////////////////////////////////////////////
    // converter models
    //////////////////////////////////////////////////

    // first bit on cs_n fall, next bit after each sclk high
    always @(negedge sys_clk_in) begin : converter_models
        if (reset_in) begin
            cs_prev = 2'b11;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (!cs_bus[k] && cs_prev[k]) begin
                    tx_frame[k] = pick_frame();
                    tx_bit[k] = W_FRAME - 1;
                    sdo_bits[k] <= tx_frame[k].raw[tx_bit[k]];
                end else if (!cs_bus[k] && sclk_bus[k] && tx_bit[k] > 0) begin
                    tx_bit[k]--;
                    sdo_bits[k] <= tx_frame[k].raw[tx_bit[k]];
                end
            end
            // frame complete once cs_n is back high
            if (cs_bus[0] && !cs_prev[0]) begin
                if (!(cs_bus[1] && !cs_prev[1])) begin
                    protocol_errs++;
                    $display("ERROR: converter b frame did not end with converter a");
                end
                ref_frame(tx_frame[0], tx_frame[1]);
                frames_done++;
            end
            cs_prev = cs_bus;
        end
    end

    //////////////////////////////////////////////////
    // frame monitor
    //////////////////////////////////////////////////

    always @(negedge sys_clk_in) begin : frame_monitor
        if (reset_in) begin
            mon_cs_prev = 2'b11;
            sclk_prev = 2'b00;
            seen_fall = 2'b00;
            for (int k = 0; k < 2; k++) begin
                low_cnt[k] = 0;
                rise_cnt[k] = 0;
                period_cnt[k] = 0;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (sclk_bus[k] && !sclk_prev[k]) begin
                    rise_cnt[k]++;
                end
                if (cs_bus[k] && sclk_bus[k]) begin
                    protocol_errs++;
                    $display("ERROR: converter %s sclk high outside chip select", k ? "b" : "a");
                end
                if (!cs_bus[k]) begin
                    low_cnt[k]++;
                end
                // period measured fall to fall
                if (!cs_bus[k] && mon_cs_prev[k]) begin
                    if (seen_fall[k] && period_cnt[k] != FRAME_CYCLES) begin
                        protocol_errs++;
                        $display("ERROR: converter %s frame took %0d cycles instead of %0d",
                                 k ? "b" : "a", period_cnt[k], FRAME_CYCLES);
                    end
                    seen_fall[k] = 1'b1;
                    period_cnt[k] = 1;
                end else begin
                    period_cnt[k]++;
                end
                if (cs_bus[k] && !mon_cs_prev[k]) begin
                    if (low_cnt[k] != SHIFT_CYCLES) begin
                        protocol_errs++;
                        $display("ERROR: converter %s chip select low %0d cycles instead of %0d",
                                 k ? "b" : "a", low_cnt[k], SHIFT_CYCLES);
                    end
                    if (rise_cnt[k] != W_FRAME) begin
                        protocol_errs++;
                        $display("ERROR: converter %s got %0d sclk edges instead of %0d",
                                 k ? "b" : "a", rise_cnt[k], W_FRAME);
                    end
                    low_cnt[k] = 0;
                    rise_cnt[k] = 0;
                end
                mon_cs_prev[k] = cs_bus[k];
                sclk_prev[k] = sclk_bus[k];
            end
        end
    end

    //////////////////////////////////////////////////
    // result comparison
    //////////////////////////////////////////////////

    always @(negedge sys_clk_in) begin : compare_results
        adc_sample_t e;
        if (!reset_in && avg_valid === 1'b1) begin
            avg_seen++;
            if (exp_q.size() == 0) begin
                protocol_errs++;
                $display("ERROR: avg_valid pulse with no expected result pending");
            end else begin
                e = exp_q.pop_front();
                if (avg_chan !== e.chan) begin
                    mismatch_errs++;
                    $display("MISMATCH avg_chan: got %h expected %h", avg_chan, e.chan);
                end
                if (avg_data !== e.data) begin
                    mismatch_errs++;
                    $display("MISMATCH avg_data: got %h expected %h", avg_data, e.data);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tasks
    //////////////////////////////////////////////////

    task automatic report_and_finish();
        $display("errors: %0d mismatch, %0d protocol, %0d timeout",
                 mismatch_errs, protocol_errs, timeout_errs);
        if (mismatch_errs + protocol_errs + timeout_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // pins idle before the first frame
    task automatic check_idle();
        if (adc_a_cs_n !== 1'b1) begin
            mismatch_errs++;
            $display("MISMATCH adc_a_cs_n: got %h expected %h", adc_a_cs_n, 1'b1);
        end
        if (adc_b_cs_n !== 1'b1) begin
            mismatch_errs++;
            $display("MISMATCH adc_b_cs_n: got %h expected %h", adc_b_cs_n, 1'b1);
        end
        if (sclk_bus !== 2'b00) begin
            mismatch_errs++;
            $display("MISMATCH sclk: got %h expected %h", sclk_bus, 2'b00);
        end
        if (avg_valid !== 1'b0) begin
            mismatch_errs++;
            $display("MISMATCH avg_valid: got %h expected %h", avg_valid, 1'b0);
        end
    endtask

    task automatic wait_frame_done(input int target, input int limit);
        int n;
        n = 0;
        while (frames_done < target && n < limit) begin
            @(negedge sys_clk_in);
            n++;
        end
        if (frames_done < target) begin
            timeout_errs++;
            $display("ERROR: timed out waiting for frame %0d to complete", target);
            report_and_finish();
        end
    endtask

    // last results come a few cycles after the frame
    task automatic wait_queue_drained(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge sys_clk_in);
            n++;
        end
        if (exp_q.size() != 0) begin
            timeout_errs++;
            $display("ERROR: %0d expected results never arrived", exp_q.size());
            report_and_finish();
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin : main_flow
        sys_clk_in = 1'b0;
        reset_in = 1'b1;
        sdo_bits <= 2'b00;
        for (int c = 0; c < N_CHAN; c++) begin
            model_sum[c] = 0;
            model_cnt[c] = 0;
        end
        for (int i = 0; i < 10; i++) begin
            @(negedge sys_clk_in);
            check_idle();
        end
        reset_in = 1'b0;
        for (int f = 1; f <= 200; f++) begin
            wait_frame_done(f, 2 * FRAME_CYCLES);
        end
        wait_queue_drained(16);
        if (avg_seen != exp_total) begin
            protocol_errs++;
            $display("ERROR: %0d results seen but %0d expected", avg_seen, exp_total);
        end
        if (same_chan_frames == 0) begin
            protocol_errs++;
            $display("ERROR: no frame had both converters on the same channel");
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

/* src.f */
logic/adc_pkg.sv
logic/adc_serial_reader.sv
logic/sample_serializer.sv
logic/oversample_filter.sv
logic/adc_subsystem.sv
bench/sample_serializer_props.sv
bench/adc_subsystem_tb.sv

/* Bender.yml */
package:
  name: adc_subsystem

sources:
  - logic/adc_pkg.sv
  - logic/adc_serial_reader.sv
  - logic/sample_serializer.sv
  - logic/oversample_filter.sv
  - logic/adc_subsystem.sv
  - target: test
    files:
      - bench/sample_serializer_props.sv
      - bench/adc_subsystem_tb.sv
